/* logic/simt_pkg.sv */
package simt_pkg;

    // Core sizes
    localparam int num_warps_max    = 4;
    localparam int threads_per_warp = 4;
    localparam int num_regs         = 16;

    typedef logic [31:0] word_t;
    typedef logic [15:0] pc_t;
    typedef logic [1:0]  warp_idx_t;
    // Valid launch sizes are 1 to 4
    typedef logic [2:0]  warp_count_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [15:0] block_id_t;
    typedef logic [31:0] instr_t;

    // Unlisted encodings decode as halt
    typedef enum logic [3:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_and  = 4'h2,
        op_or   = 4'h3,
        op_xor  = 4'h4,
        op_addi = 4'h5,
        op_li   = 4'h6,
        op_tid  = 4'h7,
        op_halt = 4'hf
    } opcode_t;

    // Instruction layout, opcode in the top nibble
    typedef struct packed {
        opcode_t     op;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [15:0] imm;
    } instr_fields_t;

    // One word per lane
    typedef word_t [threads_per_warp-1:0] lane_words_t;

    typedef struct packed {
        block_id_t   block_id;
        warp_count_t num_warps;
        pc_t         base_pc;
    } launch_t;

    typedef struct packed {
        warp_idx_t warp;
        pc_t       pc;
    } fetch_req_t;

    typedef struct packed {
        warp_idx_t warp;
        instr_t    instr;
    } fetch_rsp_t;

    typedef struct packed {
        opcode_t   op;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        word_t     imm;
        warp_idx_t warp;
    } decoded_t;

    typedef struct packed {
        warp_idx_t   warp;
        reg_idx_t    rd;
        lane_words_t result;
    } writeback_t;

endpackage

/* logic/warp_fetch.sv */
module warp_fetch (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           fetch_go,
    input  simt_pkg::launch_t                              launch,
    input  logic                                           warp_advance,
    input  logic                                           warp_stop,
    input  simt_pkg::warp_idx_t                            step_warp,
    output logic                                           fetch_req_valid,
    output simt_pkg::fetch_req_t                           fetch_req,
    input  logic                                           fetch_rsp_valid,
    input  simt_pkg::fetch_rsp_t                           fetch_rsp,
    output logic [simt_pkg::num_warps_max-1:0]             warp_ready,
    output simt_pkg::instr_t [simt_pkg::num_warps_max-1:0] instr_buf
);
    import simt_pkg::*;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_need,
        fetch_wait,
        fetch_have
    } fetch_state_t;

    fetch_state_t state [num_warps_max];
    pc_t          pc [num_warps_max];
    warp_idx_t    fetch_ptr;
    logic [num_warps_max-1:0] req_open;

    always_comb begin
        for (int w = 0; w < num_warps_max; w++) begin
            warp_ready[w] = (state[w] == fetch_have);
        end
    end

    // Round-robin pick among warps waiting to send a request
    always_comb begin
        warp_idx_t cand;
        fetch_req_valid = 1'b0;
        fetch_req = '0;
        for (int i = 0; i < num_warps_max; i++) begin
            cand = fetch_ptr + warp_idx_t'(i);
            if (!fetch_req_valid && state[cand] == fetch_need) begin
                fetch_req_valid = 1'b1;
                fetch_req.warp = cand;
                fetch_req.pc = pc[cand];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < num_warps_max; w++) begin
                state[w] <= fetch_idle;
            end
            fetch_ptr <= '0;
        end else if (fetch_go) begin
            for (int w = 0; w < num_warps_max; w++) begin
                state[w] <= (w < int'(launch.num_warps)) ? fetch_need : fetch_idle;
            end
            fetch_ptr <= '0;
        end else begin
            // Each event targets a warp in a different state
            if (fetch_req_valid) begin
                state[fetch_req.warp] <= fetch_wait;
                fetch_ptr <= fetch_req.warp + 1'b1;
            end
            if (fetch_rsp_valid) begin
                state[fetch_rsp.warp] <= fetch_have;
            end
            if (warp_advance) begin
                state[step_warp] <= fetch_need;
            end
            if (warp_stop) begin
                state[step_warp] <= fetch_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_go) begin
            for (int w = 0; w < num_warps_max; w++) begin
                pc[w] <= launch.base_pc;
            end
        end else if (warp_advance) begin
            pc[step_warp] <= pc[step_warp] + 1'b1;
        end
        if (fetch_rsp_valid) begin
            instr_buf[fetch_rsp.warp] <= fetch_rsp.instr;
        end
    end

    // Requests sent but not yet answered
    always_ff @(posedge clk) begin
        if (reset) begin
            req_open <= '0;
        end else begin
            for (int w = 0; w < num_warps_max; w++) begin
                if (fetch_req_valid && fetch_req.warp == warp_idx_t'(w)) begin
                    req_open[w] <= 1'b1;
                end else if (fetch_rsp_valid && fetch_rsp.warp == warp_idx_t'(w)) begin
                    req_open[w] <= 1'b0;
                end
            end
        end
    end

    a_rsp_expected: assert property (@(posedge clk) disable iff (reset)
        fetch_rsp_valid |-> state[fetch_rsp.warp] == fetch_wait);

    a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
        fetch_req_valid |-> !req_open[fetch_req.warp]);

endmodule

/* logic/warp_scheduler.sv */
module warp_scheduler (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           launch_valid,
    input  simt_pkg::launch_t                              launch,
    input  logic [simt_pkg::num_warps_max-1:0]             warp_ready,
    input  simt_pkg::instr_t [simt_pkg::num_warps_max-1:0] instr_buf,
    output logic                                           fetch_go,
    output logic                                           warp_advance,
    output logic                                           warp_stop,
    output simt_pkg::warp_idx_t                            step_warp,
    output logic                                           issue_valid,
    output simt_pkg::decoded_t                             issue,
    output simt_pkg::block_id_t                            block_id,
    output logic                                           done
);
    import simt_pkg::*;

    typedef enum logic {
        run_idle,
        run_running
    } run_state_t;

    run_state_t    run_state;
    warp_count_t   num_warps;
    warp_idx_t     last_warp;
    warp_idx_t     sel;
    logic          found;
    logic          all_done;
    instr_fields_t fields;
    logic [num_warps_max-1:0] halted;
    logic [num_warps_max-1:0] halted_next;

    // Search starts one past the last issued warp
    always_comb begin
        warp_idx_t idx;
        found = 1'b0;
        sel = last_warp + 1'b1;
        for (int i = 0; i < num_warps_max; i++) begin
            idx = last_warp + warp_idx_t'(i + 1);
            if (!found && warp_ready[idx]) begin
                found = 1'b1;
                sel = idx;
            end
        end
    end

    // Decode
    always_comb begin
        fields = instr_fields_t'(instr_buf[sel]);
        issue.warp = sel;
        issue.rd = fields.rd;
        issue.rs1 = fields.rs1;
        issue.rs2 = fields.rs2;
        issue.imm = {{16{fields.imm[15]}}, fields.imm};
        case (fields.op)
            op_add, op_sub, op_and, op_or, op_xor, op_addi, op_li, op_tid: begin
                issue.op = fields.op;
            end
            default: issue.op = op_halt;
        endcase
    end

    assign fetch_go = launch_valid && run_state == run_idle;
    assign issue_valid = found && run_state == run_running;
    assign warp_advance = issue_valid && issue.op != op_halt;
    assign warp_stop = issue_valid && issue.op == op_halt;
    assign step_warp = sel;

    always_comb begin
        halted_next = halted;
        if (warp_stop) begin
            halted_next[sel] = 1'b1;
        end
        all_done = 1'b1;
        for (int i = 0; i < num_warps_max; i++) begin
            if (i < int'(num_warps) && !halted_next[i]) begin
                all_done = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            run_state <= run_idle;
            num_warps <= '0;
            halted <= '0;
            last_warp <= '1;
            done <= 1'b0;
        end else if (fetch_go) begin
            run_state <= run_running;
            num_warps <= launch.num_warps;
            halted <= '0;
            last_warp <= '1;
            done <= 1'b0;
        end else if (run_state == run_running) begin
            halted <= halted_next;
            if (issue_valid) begin
                last_warp <= sel;
            end
            if (all_done) begin
                run_state <= run_idle;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_go) begin
            block_id <= launch.block_id;
        end
    end

    a_issue_live: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> !halted[issue.warp]);

endmodule

/* logic/vector_reg_file.sv */
module vector_reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  simt_pkg::decoded_t    issue,
    output simt_pkg::lane_words_t rs1_data,
    output simt_pkg::lane_words_t rs2_data,
    input  logic                  wb_valid,
    input  simt_pkg::writeback_t  wb
);
    import simt_pkg::*;

    word_t regs [num_warps_max][threads_per_warp][num_regs];

    // Operands of the issuing warp, all lanes at once
    always_comb begin
        for (int l = 0; l < threads_per_warp; l++) begin
            if (issue_valid) begin
                rs1_data[l] = regs[issue.warp][l][issue.rs1];
                rs2_data[l] = regs[issue.warp][l][issue.rs2];
            end else begin
                rs1_data[l] = '0;
                rs2_data[l] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < num_warps_max; w++) begin
                for (int l = 0; l < threads_per_warp; l++) begin
                    for (int r = 0; r < num_regs; r++) begin
                        regs[w][l][r] <= '0;
                    end
                end
            end
        end else if (wb_valid) begin
            for (int l = 0; l < threads_per_warp; l++) begin
                regs[wb.warp][l][wb.rd] <= wb.result[l];
            end
        end
    end

    // A warp refetches before it can issue again, so its write never meets its own read
    a_no_self_hazard: assert property (@(posedge clk) disable iff (reset)
        wb_valid && issue_valid |-> issue.warp != wb.warp);

endmodule

/* logic/simd_alu.sv */
module simd_alu (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  simt_pkg::decoded_t    issue,
    input  simt_pkg::lane_words_t rs1_data,
    input  simt_pkg::lane_words_t rs2_data,
    input  simt_pkg::block_id_t   block_id,
    output logic                  wb_valid,
    output simt_pkg::writeback_t  wb
);
    import simt_pkg::*;

    lane_words_t result;

    always_comb begin
        for (int l = 0; l < threads_per_warp; l++) begin
            case (issue.op)
                op_add:  result[l] = rs1_data[l] + rs2_data[l];
                op_sub:  result[l] = rs1_data[l] - rs2_data[l];
                op_and:  result[l] = rs1_data[l] & rs2_data[l];
                op_or:   result[l] = rs1_data[l] | rs2_data[l];
                op_xor:  result[l] = rs1_data[l] ^ rs2_data[l];
                op_addi: result[l] = rs1_data[l] + issue.imm;
                op_li:   result[l] = issue.imm;
                // Global thread index, 16 threads per block
                op_tid: begin
                    result[l] = word_t'(block_id) * 16
                              + word_t'(issue.warp) * word_t'(threads_per_warp)
                              + word_t'(l);
                end
                default: result[l] = '0;
            endcase
        end
    end

    // Result stage
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= issue_valid && issue.op != op_halt;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            wb.warp <= issue.warp;
            wb.rd <= issue.rd;
            wb.result <= result;
        end
    end

endmodule

/* logic/compute_core.sv */
module compute_core (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 launch_valid,
    input  simt_pkg::launch_t    launch,
    output logic                 fetch_req_valid,
    output simt_pkg::fetch_req_t fetch_req,
    input  logic                 fetch_rsp_valid,
    input  simt_pkg::fetch_rsp_t fetch_rsp,
    output logic                 wb_valid,
    output simt_pkg::writeback_t wb,
    output logic                 done
);
    import simt_pkg::*;

    // Scheduler to fetch control
    logic      fetch_go;
    logic      warp_advance;
    logic      warp_stop;
    warp_idx_t step_warp;

    logic [num_warps_max-1:0]   warp_ready;
    instr_t [num_warps_max-1:0] instr_buf;

    // Issue path
    logic        issue_valid;
    decoded_t    issue;
    lane_words_t rs1_data;
    lane_words_t rs2_data;
    block_id_t   block_id;

    warp_fetch i_fetch (
        .clk             (clk),
        .reset           (reset),
        .fetch_go        (fetch_go),
        .launch          (launch),
        .warp_advance    (warp_advance),
        .warp_stop       (warp_stop),
        .step_warp       (step_warp),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .warp_ready      (warp_ready),
        .instr_buf       (instr_buf)
    );

    warp_scheduler i_sched (
        .clk          (clk),
        .reset        (reset),
        .launch_valid (launch_valid),
        .launch       (launch),
        .warp_ready   (warp_ready),
        .instr_buf    (instr_buf),
        .fetch_go     (fetch_go),
        .warp_advance (warp_advance),
        .warp_stop    (warp_stop),
        .step_warp    (step_warp),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .block_id     (block_id),
        .done         (done)
    );

    vector_reg_file i_regs (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    simd_alu i_alu (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .block_id    (block_id),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

endmodule

/* tb/result_checker.sv */
module result_checker (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  launch_valid,
    input  simt_pkg::launch_t                                     launch,
    input  logic                                                  fetch_req_valid,
    input  simt_pkg::fetch_req_t                                  fetch_req,
    input  logic                                                  wb_valid,
    input  simt_pkg::writeback_t                                  wb,
    input  logic                                                  done,
    input  simt_pkg::instr_t [simt_pkg::num_warps_max-1:0][15:0] programs,
    input  logic                                                  test_end,
    input  int                                                    test_num,
    output int                                                    error_count,
    output int                                                    wb_count,
    output int                                                    failed_tests
);
    import simt_pkg::*;

    // Modelled register file, carried across launches
    word_t [num_regs-1:0] model_regs [num_warps_max][threads_per_warp];
    int        next_idx [num_warps_max];
    int        run_warps;
    block_id_t run_block;
    logic      active;
    logic      done_prev;
    logic      accepted_prev;
    int        pending;
    int        errors = 0;
    int        wbs = 0;
    int        fails = 0;
    int        errors_at_start = 0;
    int        wbs_at_start = 0;

    assign error_count = errors;
    assign wb_count = wbs;
    assign failed_tests = fails;

    function automatic word_t expected_word(input instr_t instr,
                                            input word_t [num_regs-1:0] lane_regs,
                                            input block_id_t blk, input int lane,
                                            input int warp);
        word_t a;
        word_t b;
        word_t imm;
        a = lane_regs[instr[23:20]];
        b = lane_regs[instr[19:16]];
        imm = {{16{instr[15]}}, instr[15:0]};
        case (instr[31:28])
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_addi: return a + imm;
            op_li:   return imm;
            // 16 threads per block
            op_tid:  return (word_t'(blk) << 4) + word_t'(warp * threads_per_warp + lane);
            default: return '0;
        endcase
    endfunction

    // Non-halt instructions ahead of the first halt in the launched warps
    function automatic int count_ops(input int nw);
        int   total;
        logic stop;
        total = 0;
        for (int w = 0; w < nw; w++) begin
            stop = 1'b0;
            for (int i = 0; i < 16; i++) begin
                if (!stop && programs[w][i][31:28] <= op_tid) begin
                    total++;
                end else begin
                    stop = 1'b1;
                end
            end
        end
        return total;
    endfunction

    function automatic string test_name(input int n);
        case (n)
            1:       return "reset";
            2:       return "four_warp_run";
            3:       return "done_hold";
            4:       return "three_warp_run";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_writeback();
        int          w;
        instr_t      instr;
        lane_words_t want;
        w = int'(wb.warp);
        wbs++;
        if (!active || w >= run_warps) begin
            $display("write-back at %0t names warp %0d, outside the %0d launched warps",
                     $time, w, run_warps);
            errors++;
        end else if (next_idx[w] > 15 || programs[w][4'(next_idx[w])][31:28] > op_tid) begin
            $display("write-back at %0t for warp %0d after its program reached halt",
                     $time, w);
            errors++;
        end else begin
            instr = programs[w][4'(next_idx[w])];
            for (int l = 0; l < threads_per_warp; l++) begin
                want[l] = expected_word(instr, model_regs[w][l], run_block, l, w);
            end
            if (wb.rd !== instr[27:24]) begin
                $display("error at %0t: wb.rd of warp %0d is %0d, expected %0d",
                         $time, w, wb.rd, instr[27:24]);
                errors++;
            end
            for (int l = 0; l < threads_per_warp; l++) begin
                if (wb.result[l] !== want[l]) begin
                    $display("error at %0t: wb.result[%0d] of warp %0d is %08h, expected %08h",
                             $time, l, w, wb.result[l], want[l]);
                    errors++;
                end
                model_regs[w][l][instr[27:24]] = want[l];
            end
            next_idx[w]++;
            pending--;
        end
    endtask

    always @(negedge clk) begin
        if (reset) begin
            if (fetch_req_valid || wb_valid || done) begin
                $display("outputs active during reset at %0t: fetch_req_valid %0b wb_valid %0b done %0b",
                         $time, fetch_req_valid, wb_valid, done);
                errors++;
            end
            for (int w = 0; w < num_warps_max; w++) begin
                for (int l = 0; l < threads_per_warp; l++) begin
                    model_regs[w][l] = '0;
                end
            end
            active = 1'b0;
            done_prev = 1'b0;
            accepted_prev = 1'b0;
            run_warps = 0;
            pending = 0;
        end else begin
            if (done_prev && !done && !accepted_prev) begin
                $display("done fell at %0t without a new launch", $time);
                errors++;
            end
            accepted_prev = 1'b0;
            if (fetch_req_valid && (!active || int'(fetch_req.warp) >= run_warps)) begin
                $display("fetch request at %0t names warp %0d outside the launched warps",
                         $time, fetch_req.warp);
                errors++;
            end
            if (wb_valid) begin
                check_writeback();
            end
            if (done && active) begin
                if (pending != 0) begin
                    $display("done rose at %0t with %0d write-backs still missing",
                             $time, pending);
                    errors++;
                end
                active = 1'b0;
            end
            // A launch only takes effect while no run is active
            if (launch_valid && active) begin
                $display("launch at %0t ignored while a run is active", $time);
            end else if (launch_valid) begin
                accepted_prev = 1'b1;
                active = 1'b1;
                run_warps = int'(launch.num_warps);
                run_block = launch.block_id;
                pending = count_ops(run_warps);
                for (int w = 0; w < num_warps_max; w++) begin
                    next_idx[w] = 0;
                end
            end
            done_prev = done;
        end
        if (test_end) begin
            if (errors != errors_at_start) begin
                fails++;
            end
            $display("test %0d %s: %s, %0d errors, %0d write-backs", test_num,
                     test_name(test_num), (errors == errors_at_start) ? "pass" : "fail",
                     errors - errors_at_start, wbs - wbs_at_start);
            errors_at_start = errors;
            wbs_at_start = wbs;
        end
    end

endmodule

/* tb/tb_top.sv */
module tb_top;
    import simt_pkg::*;

    logic       clk;
    logic       reset;
    logic       launch_valid;
    launch_t    launch;
    logic       fetch_req_valid;
    fetch_req_t fetch_req;
    logic       fetch_rsp_valid = 1'b0;
    fetch_rsp_t fetch_rsp = '0;
    logic       wb_valid;
    writeback_t wb;
    logic       done;

    // Two program sets, one per launch, each indexed [warp][offset from base_pc]
    instr_t [num_warps_max-1:0][15:0] prog_set [2];
    instr_t [num_warps_max-1:0][15:0] programs;
    logic prog_sel;
    pc_t  mem_base;

    int cycle = 0;
    int cycle_limit = 0;
    int words_a;
    int words_b;

    // Outstanding fetches and the cycle each may be answered
    fetch_req_t pend_req [$];
    int         pend_due [$];

    logic test_end;
    int   test_num;
    int   error_count;
    int   wb_count;
    int   failed_tests;

    assign programs = prog_set[prog_sel];

    compute_core i_compute_core (
        .clk             (clk),
        .reset           (reset),
        .launch_valid    (launch_valid),
        .launch          (launch),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .wb_valid        (wb_valid),
        .wb              (wb),
        .done            (done)
    );

    result_checker i_checker (
        .clk             (clk),
        .reset           (reset),
        .launch_valid    (launch_valid),
        .launch          (launch),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req),
        .wb_valid        (wb_valid),
        .wb              (wb),
        .done            (done),
        .programs        (programs),
        .test_end        (test_end),
        .test_num        (test_num),
        .error_count     (error_count),
        .wb_count        (wb_count),
        .failed_tests    (failed_tests)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Random ALU ops, then halt; unused slots hold halts tagged with their address
    task automatic make_programs(input int set, output int words);
        int len;
        int tid_pos;
        words = 0;
        for (int w = 0; w < num_warps_max; w++) begin
            len = 6 + int'($urandom_range(6, 0));
            // Every program holds at least one op_tid
            tid_pos = int'($urandom_range(len - 1, 0));
            for (int i = 0; i < 16; i++) begin
                if (i == tid_pos) begin
                    prog_set[set][w][i] = {op_tid, 4'($urandom), 4'($urandom),
                                           4'($urandom), 16'($urandom)};
                end else if (i < len) begin
                    prog_set[set][w][i] = {4'($urandom_range(7, 0)), 4'($urandom),
                                           4'($urandom), 4'($urandom), 16'($urandom)};
                end else begin
                    prog_set[set][w][i] = {op_halt, 22'h0, 2'(w), 4'(i)};
                end
            end
            words += len + 1;
        end
    endtask

    task automatic send_launch(input block_id_t blk, input warp_count_t nw, input pc_t base);
        @(posedge clk);
        #2;
        launch_valid = 1'b1;
        launch.block_id = blk;
        launch.num_warps = nw;
        launch.base_pc = base;
        @(posedge clk);
        #2;
        launch_valid = 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
    endtask

    task automatic end_test(input int n);
        @(posedge clk);
        #2;
        test_num = n;
        test_end = 1'b1;
        @(posedge clk);
        #2;
        test_end = 1'b0;
    endtask

    // Memory model, request capture
    always @(negedge clk) begin
        if (!reset && fetch_req_valid) begin
            pend_req.push_back(fetch_req);
            pend_due.push_back(cycle + 1 + int'($urandom_range(3, 0)));
        end
    end

    // Memory model, at most one answer per cycle, picked at random among the due ones
    always @(posedge clk) begin : mem_answer
        int   ready_idx [$];
        int   pick;
        pc_t  offset;
        #2;
        fetch_rsp_valid = 1'b0;
        if (reset) begin
            pend_req.delete();
            pend_due.delete();
        end else begin
            ready_idx.delete();
            foreach (pend_due[i]) begin
                if (pend_due[i] <= cycle) begin
                    ready_idx.push_back(i);
                end
            end
            if (ready_idx.size() > 0) begin
                pick = ready_idx[$urandom_range(ready_idx.size() - 1, 0)];
                offset = pend_req[pick].pc - mem_base;
                fetch_rsp.warp = pend_req[pick].warp;
                if (offset < 16) begin
                    fetch_rsp.instr = programs[pend_req[pick].warp][offset[3:0]];
                end else begin
                    fetch_rsp.instr = {op_halt, 12'h0, offset};
                end
                fetch_rsp_valid = 1'b1;
                pend_req.delete(pick);
                pend_due.delete(pick);
            end
        end
    end

    initial begin
        #1;
        while (cycle < cycle_limit) begin
            @(posedge clk);
        end
        $display("timeout: no verdict after %0d cycles", cycle);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h9a2d));
        reset = 1'b1;
        launch_valid = 1'b0;
        launch = '0;
        test_end = 1'b0;
        test_num = 0;
        prog_sel = 1'b0;
        mem_base = '0;
        make_programs(0, words_a);
        make_programs(1, words_b);
        cycle_limit = 40 * (words_a + words_b) + 200;

        repeat (6) @(posedge clk);
        // A launch strobe under reset must leave the core idle
        send_launch(16'h0001, 3'd4, 16'h0000);
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        end_test(1);

        // Four warps, plus a launch strobe in the middle of the run
        mem_base = 16'h0100;
        send_launch(16'h0005, 3'd4, 16'h0100);
        repeat (6) @(posedge clk);
        send_launch(16'h0777, 3'd1, 16'h0300);
        wait_done();
        end_test(2);

        // done must hold while idle
        repeat (8) @(posedge clk);
        end_test(3);

        // Three warps, new block and base, registers carried over
        prog_sel = 1'b1;
        mem_base = 16'h0200;
        send_launch(16'h0a3c, 3'd3, 16'h0200);
        wait_done();
        repeat (6) @(posedge clk);
        end_test(4);

        @(posedge clk);
        #2;
        $display("summary: 4 tests, %0d failing, %0d write-backs checked, %0d errors",
                 failed_tests, wb_count, error_count);
        if (error_count == 0 && failed_tests == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
logic/simt_pkg.sv
logic/warp_fetch.sv
logic/warp_scheduler.sv
logic/vector_reg_file.sv
logic/simd_alu.sv
logic/compute_core.sv
tb/result_checker.sv
tb/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
